// File: hdl/loader_pkg.sv
`default_nettype none

package loader_pkg;

    typedef logic [11:0] page_t;        // flash page number
    typedef logic [2:0]  img_t;         // image select
    typedef logic [14:0] buf_addr_t;    // output buffer bit address
    typedef logic [11:0] map_addr_t;    // bad-loop map index

    localparam logic [7:0] read_opcode = 8'h03;     // plain serial read

    // first of the four bootloader pages of an image
    localparam page_t boot_page = 12'h805;

    localparam buf_addr_t boot_buf_base = 15'd4106;     // bootloader area in buffer
    localparam buf_addr_t page_buf_base = 15'd14336;    // page data area in buffer

    // flash byte address is {image, page, byte}, 128 bytes per page
    typedef struct packed {
        logic [7:0]  opcode;        // sent first
        logic [1:0]  pad;           // upper address bits, unused
        img_t        image;
        page_t       page;
        logic [6:0]  byte_offset;   // always from the start of a page
    } read_cmd_fields_t;

    // built as fields, shifted out as a plain word
    typedef union packed {
        read_cmd_fields_t fields;
        logic [31:0]      raw;
    } read_cmd_t;

endpackage

`default_nettype wire

// File: hdl/loop_map_table.sv
`default_nettype none

module loop_map_table
    import loader_pkg::*;
(
    input  wire logic   MCLK,
    input  wire logic   rst,
    input  wire logic   map_clear,      // address back to zero
    input  wire logic   map_wr,         // write then advance
    input  wire logic   map_rd,         // read then advance
    input  wire logic   map_din,
    output logic        map_bit         // 1 good loop, 0 bad loop
);

    logic      mem [4096];
    map_addr_t addr;
    map_addr_t wr_addr;

    // map arrives from flash with each nibble reversed
    assign wr_addr = {addr[11:4], ~addr[3:0]};

    always_ff @(posedge MCLK)
    begin
        if (rst)
            addr <= '0;
        else if (map_clear)
            addr <= '0;
        else if (map_wr || map_rd)
            addr <= addr + 12'd1;   // linear walk for both
    end

    always_ff @(posedge MCLK)
    begin
        if (map_wr)
            mem[wr_addr] <= map_din;
        if (map_rd)
            map_bit <= mem[addr];   // held until next read
    end

endmodule

`default_nettype wire

// File: hdl/read_command_shifter.sv
`default_nettype none

module read_command_shifter
    import loader_pkg::*;
(
    input  wire logic   MCLK,
    input  wire logic   rst,
    input  wire logic   cmd_load,       // capture pulse
    input  wire logic   cmd_shift,      // one bit per pulse
    input  wire logic   page_read,
    input  wire img_t   img_num,
    input  wire page_t  page,
    output logic        mosi
);

    read_cmd_t   cmd;
    logic [32:0] sr;                    // leading zero + command word

    always_comb
    begin
        cmd.fields.opcode      = read_opcode;
        cmd.fields.pad         = 2'b00;
        cmd.fields.image       = img_num;
        cmd.fields.page        = page_read ? page : boot_page;
        cmd.fields.byte_offset = 7'd0;
    end

    always_ff @(posedge MCLK)
    begin
        if (rst)
            sr <= '0;
        else if (cmd_load)
            sr <= {1'b0, cmd.raw};      // mosi stays low until first shift
        else if (cmd_shift)
            sr <= {sr[31:0], 1'b0};     // msb first
    end

    assign mosi = sr[32];

endmodule

`default_nettype wire

// File: hdl/loader_sequencer.sv
`default_nettype none

module loader_sequencer
    import loader_pkg::*;
#(
    parameter int boot_bits,
    parameter int map_bits,
    parameter int lead_loops,
    parameter int page_loops
)
(
    input  wire logic      MCLK,
    input  wire logic      rst,
    input  wire logic      access,
    input  wire logic      page_read,
    input  wire logic      miso,
    input  wire logic      map_bit,     // valid the cycle after map_rd
    output logic           cmd_load,
    output logic           cmd_shift,
    output logic           map_clear,
    output logic           map_wr,
    output logic           map_rd,
    output logic           map_din,
    output logic           cs_n,
    output logic           sclk,
    output logic           buf_wr_n,
    output buf_addr_t      buf_addr,
    output logic           buf_data
);

    localparam logic [11:0] cmd_bits  = 12'd32;     // opcode + 24 bit address
    localparam logic [11:0] boot_last = 12'(boot_bits - 1);
    localparam logic [11:0] map_last  = 12'(map_bits - 1);
    localparam logic [11:0] lead_last = 12'(lead_loops - 1);
    localparam logic [11:0] page_last = 12'(page_loops - 1);

    localparam logic [4:0] s_idle     = 5'd0;   // armed, waits for access
    localparam logic [4:0] s_wait     = 5'd1;   // job done, waits for access low
    localparam logic [4:0] s_start    = 5'd2;
    localparam logic [4:0] s_load     = 5'd3;   // command captured by shifter
    localparam logic [4:0] s_select   = 5'd4;   // chip select falls
    localparam logic [4:0] s_cmd_lo   = 5'd5;
    localparam logic [4:0] s_cmd_hi   = 5'd6;
    localparam logic [4:0] s_boot_lo  = 5'd7;
    localparam logic [4:0] s_boot_hi  = 5'd8;
    localparam logic [4:0] s_boot_wr  = 5'd9;
    localparam logic [4:0] s_boot_nx  = 5'd10;
    localparam logic [4:0] s_lead_rd  = 5'd11;
    localparam logic [4:0] s_lead_set = 5'd12;
    localparam logic [4:0] s_lead_wr  = 5'd13;
    localparam logic [4:0] s_lead_nx  = 5'd14;
    localparam logic [4:0] s_pg_lo    = 5'd15;
    localparam logic [4:0] s_pg_hi    = 5'd16;
    localparam logic [4:0] s_pg_sel   = 5'd17;
    localparam logic [4:0] s_pg_wr    = 5'd18;
    localparam logic [4:0] s_pg_nx    = 5'd19;

    logic [4:0]  state;
    logic [11:0] cnt;           // command bits, boot bits, map bits or good loops
    logic        page_job;      // latched with the command
    logic        map_phase;     // boot job past the bootloader

    assign cmd_load  = (state == s_load);
    assign cmd_shift = (state == s_cmd_lo);             // mosi moves as sclk falls
    assign map_clear = (state == s_start);
    assign map_wr    = (state == s_boot_wr) && map_phase;
    assign map_rd    = (state == s_lead_rd) || (state == s_pg_hi);
    assign map_din   = buf_data;                        // map gets the same flash bit

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            state     <= s_idle;
            cnt       <= '0;
            page_job  <= 1'b0;
            map_phase <= 1'b0;
            cs_n      <= 1'b1;
            sclk      <= 1'b1;
            buf_wr_n  <= 1'b1;
            buf_addr  <= '0;
        end
        else
        begin
            case (state)
                s_idle:
                    if (access)
                        state <= s_start;
                s_wait:
                    if (!access)
                        state <= s_idle;    // rearm only after access drops
                s_start:
                begin
                    cnt       <= '0;
                    map_phase <= 1'b0;
                    state     <= s_load;
                end
                s_load:
                begin
                    page_job <= page_read;  // same sample as the shifter
                    state    <= s_select;
                end
                s_select:
                begin
                    cs_n  <= 1'b0;
                    state <= s_cmd_lo;
                end
                s_cmd_lo:
                begin
                    sclk  <= 1'b0;
                    cnt   <= cnt + 12'd1;
                    state <= s_cmd_hi;
                end
                s_cmd_hi:
                begin
                    sclk <= 1'b1;           // flash latches command bit
                    if (cnt == cmd_bits)
                    begin
                        cnt      <= '0;
                        buf_addr <= page_job ? page_buf_base : boot_buf_base;
                        state    <= page_job ? s_lead_rd : s_boot_lo;
                    end
                    else
                        state <= s_cmd_lo;
                end
                s_boot_lo:
                begin
                    sclk  <= 1'b0;          // flash drives next bit
                    state <= s_boot_hi;
                end
                s_boot_hi:
                begin
                    sclk  <= 1'b1;
                    state <= s_boot_wr;
                end
                s_boot_wr:
                begin
                    buf_wr_n <= 1'b0;
                    state    <= s_boot_nx;
                end
                s_boot_nx:
                begin
                    buf_wr_n <= 1'b1;
                    buf_addr <= buf_addr + 15'd1;
                    state    <= s_boot_lo;
                    if (!map_phase && cnt == boot_last)
                    begin
                        map_phase <= 1'b1;  // map follows bootloader directly
                        cnt       <= '0;
                    end
                    else if (map_phase && cnt == map_last)
                    begin
                        cs_n  <= 1'b1;
                        state <= s_wait;
                    end
                    else
                        cnt <= cnt + 12'd1;
                end
                s_lead_rd:
                    state <= s_lead_set;
                s_lead_set:
                    state <= s_lead_wr;
                s_lead_wr:
                begin
                    buf_wr_n <= 1'b0;
                    state    <= s_lead_nx;
                end
                s_lead_nx:
                begin
                    buf_wr_n <= 1'b1;
                    buf_addr <= buf_addr + 15'd1;
                    state    <= s_lead_rd;
                    if (map_bit)            // only good loops count
                    begin
                        if (cnt == lead_last)
                        begin
                            cnt   <= '0;
                            state <= s_pg_lo;
                        end
                        else
                            cnt <= cnt + 12'd1;
                    end
                end
                s_pg_lo:
                begin
                    sclk  <= 1'b0;
                    state <= s_pg_hi;
                end
                s_pg_hi:
                begin
                    sclk  <= 1'b1;          // already high after a bad loop
                    state <= s_pg_sel;
                end
                s_pg_sel:
                    state <= s_pg_wr;
                s_pg_wr:
                begin
                    buf_wr_n <= 1'b0;
                    state    <= s_pg_nx;
                end
                s_pg_nx:
                begin
                    buf_wr_n <= 1'b1;
                    buf_addr <= buf_addr + 15'd1;
                    if (!map_bit)
                        state <= s_pg_hi;   // bad loop, keep same flash bit
                    else if (cnt == page_last)
                    begin
                        cs_n  <= 1'b1;
                        state <= s_wait;
                    end
                    else
                    begin
                        cnt   <= cnt + 12'd1;
                        state <= s_pg_lo;
                    end
                end
                default:
                    state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge MCLK)
    begin
        case (state)
            s_boot_hi, s_pg_hi:
                buf_data <= miso;           // sampled as sclk rises
            s_lead_set:
                buf_data <= map_bit;        // lead loops are map only
            s_pg_sel:
                if (!map_bit)
                    buf_data <= 1'b0;       // bad loop reads as zero
            default:
                buf_data <= buf_data;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/spi_loader_top.sv
`default_nettype none

module spi_loader_top
    import loader_pkg::*;
#(
    parameter int boot_bits  = 2656,    // bootloader bits per image
    parameter int map_bits   = 1200,    // map bits after the bootloader, last 32 unused
    parameter int lead_loops = 6,       // leading loop bits of a page
    parameter int page_loops = 1030     // good loops per page
)
(
    input  wire logic      MCLK,
    input  wire logic      rst,
    input  wire img_t      img_num,     // image select
    input  wire page_t     page,        // requested page
    input  wire logic      access,      // level, job request
    input  wire logic      page_read,   // level, 1 page job, 0 boot job
    output logic           buf_wr_n,    // buffer write strobe, active low
    output buf_addr_t      buf_addr,
    output logic           buf_data,
    output logic           cs_n,        // serial flash pins
    output logic           sclk,
    output logic           mosi,
    input  wire logic      miso
);

    logic cmd_load;     // sequencer -> shifter
    logic cmd_shift;
    logic map_clear;    // sequencer <-> map
    logic map_wr;
    logic map_rd;
    logic map_din;
    logic map_bit;

    loader_sequencer #(
        .boot_bits  (boot_bits),
        .map_bits   (map_bits),
        .lead_loops (lead_loops),
        .page_loops (page_loops)
    ) u_seq (
        .MCLK       (MCLK),
        .rst        (rst),
        .access     (access),
        .page_read  (page_read),
        .miso       (miso),
        .map_bit    (map_bit),
        .cmd_load   (cmd_load),
        .cmd_shift  (cmd_shift),
        .map_clear  (map_clear),
        .map_wr     (map_wr),
        .map_rd     (map_rd),
        .map_din    (map_din),
        .cs_n       (cs_n),
        .sclk       (sclk),
        .buf_wr_n   (buf_wr_n),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data)
    );

    read_command_shifter u_cmd (
        .MCLK       (MCLK),
        .rst        (rst),
        .cmd_load   (cmd_load),
        .cmd_shift  (cmd_shift),
        .page_read  (page_read),
        .img_num    (img_num),
        .page       (page),
        .mosi       (mosi)
    );

    loop_map_table u_map (
        .MCLK       (MCLK),
        .rst        (rst),
        .map_clear  (map_clear),
        .map_wr     (map_wr),
        .map_rd     (map_rd),
        .map_din    (map_din),
        .map_bit    (map_bit)
    );

endmodule

`default_nettype wire

// File: testbench/flash_model.sv
`default_nettype none

module flash_model
    import loader_pkg::*;
(
    input  wire logic   cs_n,
    input  wire logic   sclk,
    input  wire logic   mosi,
    output logic        miso
);

    timeunit 1ns;
    timeprecision 100ps;

    logic        img_bits [int unsigned];   // sparse bit image, filled by the tb
    logic [31:0] shift_in = '0;              // command as it arrives
    logic [31:0] last_cmd = '0;              // last complete command
    int          cmd_cnt  = 0;
    int unsigned bit_ptr  = 0;              // next data bit address
    logic        miso_q   = 1'b0;

    assign miso = miso_q;

    function automatic logic read_bit(int unsigned a);
        if (img_bits.exists(a))
            return img_bits[a];
        return 1'b0;                        // erased area reads as zero here
    endfunction

    // command bits latched on rising sclk, msb first
    always @(posedge sclk)
    begin
        if (!cs_n && cmd_cnt < 32)
        begin
            shift_in = {shift_in[30:0], mosi};
            cmd_cnt  = cmd_cnt + 1;
            if (cmd_cnt == 32)
            begin
                last_cmd = shift_in;
                bit_ptr  = {5'd0, shift_in[23:0], 3'd0};    // byte address * 8
            end
        end
    end

    // data moves on falling sclk once the command is in
    always @(negedge sclk)
    begin
        if (!cs_n && cmd_cnt == 32)
        begin
            miso_q  = read_bit(bit_ptr);
            bit_ptr = bit_ptr + 1;
        end
    end

    always @(posedge cs_n)
        cmd_cnt = 0;                        // deselect ends the read

endmodule

`default_nettype wire

// File: testbench/loader_assertions.sv
`default_nettype none

module loader_assertions
    import loader_pkg::*;
(
    input  wire logic      MCLK,
    input  wire logic      rst,
    input  wire logic      cs_n,
    input  wire logic      sclk,
    input  wire logic      buf_wr_n,
    input  wire buf_addr_t buf_addr
);

    timeunit 1ns;
    timeprecision 100ps;

    int        fail_count = 0;  // read by the tb at the end
    buf_addr_t last_addr;       // address of the previous strobe
    logic      strobed;         // a strobe seen since cs_n fell

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            strobed   <= 1'b0;
            last_addr <= '0;
        end
        else if (cs_n)
            strobed <= 1'b0;        // new job starts fresh
        else if (!buf_wr_n)
        begin
            strobed   <= 1'b1;
            last_addr <= buf_addr;
        end
    end

    // flash clock idles high while deselected
    a_sclk_idle: assert property (@(posedge MCLK) disable iff (rst) cs_n |-> sclk)
        else
        begin
            fail_count = fail_count + 1;
            $error("sclk low while cs_n high");
        end

    a_strobe_len: assert property (@(posedge MCLK) disable iff (rst) !buf_wr_n |=> buf_wr_n)
        else
        begin
            fail_count = fail_count + 1;
            $error("buf_wr_n low longer than a cycle");
        end

    // next strobe lands on the following bit
    a_addr_step: assert property (@(posedge MCLK) disable iff (rst)
        (!buf_wr_n && strobed) |-> buf_addr == last_addr + 15'd1)
        else
        begin
            fail_count = fail_count + 1;
            $error("buf_addr did not step by one");
        end

endmodule

`default_nettype wire

// File: testbench/tb_spi_loader.sv
`default_nettype none

module tb_spi_loader
    import loader_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    logic      MCLK;
    logic      rst;
    img_t      img_num;
    page_t     page;
    logic      access;
    logic      page_read;
    logic      buf_wr_n;
    buf_addr_t buf_addr;
    logic      buf_data;
    logic      cs_n;
    logic      sclk;
    logic      mosi;
    logic      miso;

    logic [31:0] lfsr_state = 32'hfb75_c6fd;
    logic        flash_img [int unsigned];  // tb copy of flash contents
    logic        shadow [32768];            // captured output buffer
    logic        map_stream [1200];         // map bits as sent from flash
    int          wr_count = 0;
    int          checks   = 0;
    int          errors   = 0;

    spi_loader_top dut (
        .MCLK(MCLK), .rst(rst), .img_num(img_num), .page(page),
        .access(access), .page_read(page_read),
        .buf_wr_n(buf_wr_n), .buf_addr(buf_addr), .buf_data(buf_data),
        .cs_n(cs_n), .sclk(sclk), .mosi(mosi), .miso(miso)
    );

    flash_model flash (.cs_n(cs_n), .sclk(sclk), .mosi(mosi), .miso(miso));

    bind loader_sequencer loader_assertions u_assert (
        .MCLK(MCLK), .rst(rst), .cs_n(cs_n), .sclk(sclk),
        .buf_wr_n(buf_wr_n), .buf_addr(buf_addr)
    );

    initial
    begin
        MCLK = 1'b0;
        forever #10 MCLK = ~MCLK;           // 20 ns period
    end

    // strobe is one full cycle wide, so negedge sees it once
    always @(negedge MCLK)
    begin
        if (buf_wr_n === 1'b0)
        begin
            shadow[buf_addr] = buf_data;
            wr_count = wr_count + 1;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int unsigned flash_base(img_t i, page_t p);
        return {5'd0, 2'b00, i, p, 7'd0, 3'd0};    // bit address of page start
    endfunction

    function automatic logic map_linear(int a);
        logic [11:0] idx;
        idx = 12'(a);
        idx = {idx[11:4], ~idx[3:0]};       // nibble reversal of the load
        if (idx >= 12'd1200)
            return 1'b1;
        return map_stream[idx];
    endfunction

    task automatic put_bit(int unsigned a, logic v);
        flash_img[a] = v;
        flash.img_bits[a] = v;
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        checks = checks + 1;
        if (got !== exp)
        begin
            errors = errors + 1;
            $display("error t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(string name, buf_addr_t got, buf_addr_t exp);
        checks = checks + 1;
        if (got !== exp)
        begin
            errors = errors + 1;
            $display("error t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_cmd(read_cmd_t got, read_cmd_t exp);
        checks = checks + 1;
        if (got.fields.opcode !== exp.fields.opcode || got.fields.pad !== exp.fields.pad
            || got.fields.image !== exp.fields.image || got.fields.page !== exp.fields.page
            || got.fields.byte_offset !== exp.fields.byte_offset)
        begin
            errors = errors + 1;
            $display("error t=%0t cmd got %h expected %h", $time, got.raw, exp.raw);
        end
    endtask

    task automatic abort_run(string what);
        $display("timeout: %s", what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // drive a request and wait for the job to end, access left high
    task automatic run_job(img_t i, page_t p, logic pr);
        int n;
        @(posedge MCLK);
        #2;
        img_num   = i;
        page      = p;
        page_read = pr;
        access    = 1'b1;
        n = 0;
        do
        begin
            @(negedge MCLK);
            n = n + 1;
        end
        while (cs_n !== 1'b0 && n < 20);
        if (cs_n !== 1'b0)
            abort_run("cs_n never fell");
        else
        begin
            n = 0;
            do
            begin
                @(negedge MCLK);
                n = n + 1;
            end
            while (cs_n !== 1'b1 && n < 40000);
            if (cs_n !== 1'b1)
                abort_run("cs_n never rose at end of job");
        end
    endtask

    task automatic drop_access();
        @(posedge MCLK);
        #2;
        access = 1'b0;
        repeat (2) @(posedge MCLK);         // let the FSM rearm
    endtask

    task automatic check_cmd(img_t i, page_t p);
        read_cmd_t exp;
        exp.fields.opcode      = 8'd3;
        exp.fields.pad         = 2'b00;
        exp.fields.image       = i;
        exp.fields.page        = p;
        exp.fields.byte_offset = 7'd0;
        compare_cmd(read_cmd_t'(flash.last_cmd), exp);
    endtask

    // map_mode 0 random, 1 all good, 2 sparse bad loops in first 256
    task automatic boot_job(img_t i, int map_mode);
        int unsigned base;
        logic        v;
        base = flash_base(i, 12'h805);
        for (int k = 0; k < 2656; k++)
            put_bit(base + k, next_bit());
        for (int m = 0; m < 1200; m++)
        begin
            if (map_mode == 0)
                v = next_bit();
            else if (map_mode == 1 || m >= 256)
                v = 1'b1;
            else
                v = !(next_bit() & next_bit() & next_bit() & next_bit());
            map_stream[m] = v;
            put_bit(base + 2656 + m, v);
        end
        run_job(i, 12'h805, 1'b0);
        check_cmd(i, 12'h805);
        for (int k = 0; k < 3856; k++)
            compare_bit("buf_data boot", shadow[15'd4106 + 15'(k)], flash_img[base + k]);
        compare_addr("buf_addr boot end", buf_addr, 15'd4106 + 15'd3856);
        drop_access();
    endtask

    task automatic page_job(img_t i, page_t p);
        int unsigned base;
        int          a;
        int          good;
        int          fp;
        logic        exp;
        base = flash_base(i, p);
        for (int k = 0; k < 1030; k++)
            put_bit(base + k, next_bit());
        run_job(i, p, 1'b1);
        check_cmd(i, p);
        a    = 0;
        good = 0;
        fp   = 0;
        while (good < 6 + 1030)
        begin
            if (!map_linear(a))
                exp = 1'b0;                 // bad loop, no flash bit used
            else if (good < 6)
            begin
                exp  = 1'b1;
                good = good + 1;
            end
            else
            begin
                exp  = flash_img[base + fp];
                fp   = fp + 1;
                good = good + 1;
            end
            compare_bit("buf_data page", shadow[15'd14336 + 15'(a)], exp);
            a = a + 1;
        end
        compare_addr("buf_addr page end", buf_addr, 15'd14336 + 15'(a));
    endtask

    task automatic report_test(string name, int start_errors);
        $display("%s: %s", name, (errors == start_errors) ? "ok" : "mismatches found");
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        for (int c = 0; c < 20; c++)
        begin
            @(negedge MCLK);
            compare_bit("cs_n", cs_n, 1'b1);
            compare_bit("sclk", sclk, 1'b1);
            compare_bit("buf_wr_n", buf_wr_n, 1'b1);
            compare_addr("buf_addr", buf_addr, 15'd0);
        end
        report_test("reset", e);
    endtask

    task automatic test_boot_load();
        int e;
        e = errors;
        boot_job(3'd5, 0);
        report_test("boot load", e);
    endtask

    task automatic test_page_all_good();
        int    e;
        page_t p;
        e = errors;
        boot_job(3'd2, 1);
        for (int k = 0; k < 12; k++)
            p[k] = next_bit();
        page_job(3'd2, p);
        drop_access();
        report_test("page all good", e);
    endtask

    task automatic test_page_bad_loops();
        int e;
        e = errors;
        boot_job(3'd6, 2);
        page_job(3'd6, 12'h1a3);
        drop_access();
        report_test("page bad loops", e);
    endtask

    task automatic test_image_repeat();
        int e;
        int w;
        e = errors;
        page_job(3'd1, 12'h044);
        w = wr_count;
        repeat (100)
        begin
            @(negedge MCLK);                // access still high here
            compare_bit("cs_n hold", cs_n, 1'b1);
        end
        checks = checks + 1;
        if (wr_count != w)
        begin
            errors = errors + 1;
            $display("buffer written again before access was dropped");
        end
        drop_access();
        page_job(3'd7, 12'hf3c);
        drop_access();
        report_test("image select and repeat", e);
    endtask

    initial
    begin
        rst       = 1'b1;
        img_num   = '0;
        page      = '0;
        access    = 1'b0;
        page_read = 1'b0;
        for (int k = 0; k < 32768; k++)
            shadow[k] = 1'b0;
        repeat (2) @(posedge MCLK);
        #2;
        rst = 1'b0;
        test_reset();
        test_boot_load();
        test_page_all_good();
        test_page_bad_loops();
        test_image_repeat();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_seq.u_assert.fail_count);
        if (errors == 0 && dut.u_seq.u_assert.fail_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/loader_pkg.sv
hdl/loop_map_table.sv
hdl/read_command_shifter.sv
hdl/loader_sequencer.sv
hdl/spi_loader_top.sv
testbench/flash_model.sv
testbench/loader_assertions.sv
testbench/tb_spi_loader.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -f list.f --top-module tb_spi_loader -o sim_tb && \
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Simulation finished: PASS" && exit 0 || exit 1
